//--- logic/axil_csr_fsm.sv
`timescale 1ns/10ps

module axil_csr_fsm (
    input  logic                            clk,
    input  logic                            rst,
    // write address
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [csr_pkg::axi_addr_width-1:0] awaddr,
    // write data
    input  logic                            wvalid,
    output logic                            wready,
    input  csr_pkg::csr_word_t              wdata,
    // write response
    output logic                            bvalid,
    input  logic                            bready,
    output csr_pkg::axi_resp_t              bresp,
    // read address
    input  logic                            arvalid,
    output logic                            arready,
    input  logic [csr_pkg::axi_addr_width-1:0] araddr,
    // read data
    output logic                            rvalid,
    input  logic                            rready,
    output csr_pkg::csr_word_t              rdata,
    output csr_pkg::axi_resp_t              rresp,
    // CSR side
    csr_access_if.fsm                       acc
);
    import csr_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wr_resp,
        st_rd_resp
    } state_t;

    state_t state;
    logic   wr_hs;
    logic   rd_hs;

    // ----------------------------------------------------------------------
    // address acceptance, writes first
    // ----------------------------------------------------------------------
    assign wr_hs = (state == st_idle) && awvalid && wvalid;
    assign rd_hs = (state == st_idle) && !wr_hs && arvalid;

    assign awready = wr_hs;
    assign wready  = wr_hs;
    assign arready = rd_hs;

    // access goes out on the handshake cycle
    assign acc.req   = wr_hs || rd_hs;
    assign acc.we    = wr_hs;
    assign acc.addr  = csr_addr_t'(wr_hs ? awaddr[13:2] : araddr[13:2]);
    // op bits only matter for writes
    assign acc.op    = csr_op_t'(awaddr[15:14]);
    assign acc.wdata = wdata;

    // ----------------------------------------------------------------------
    // state machine
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (wr_hs) begin
                        state <= st_wr_resp;
                    end else if (rd_hs) begin
                        state <= st_rd_resp;
                    end
                end
                st_wr_resp: begin
                    if (bready) begin
                        state <= st_idle;
                    end
                end
                st_rd_resp: begin
                    if (rready) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // read value captured with the address
    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata <= acc.rdata;
        end
    end

    assign bvalid = (state == st_wr_resp);
    assign rvalid = (state == st_rd_resp);
    assign bresp  = resp_okay;
    assign rresp  = resp_okay;

    // responses held until taken
    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid
    );

    a_rvalid_hold: assert property (
        @(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata)
    );

endmodule

//--- logic/csr_access_if.sv
`timescale 1ns/10ps

// one CSR access per req strobe, bus side to register side
interface csr_access_if;
    import csr_pkg::*;

    logic      req;
    logic      we;
    csr_addr_t addr;
    csr_op_t   op;
    csr_word_t wdata;
    // combinational read value of addr
    csr_word_t rdata;

    modport fsm (
        output req,
        output we,
        output addr,
        output op,
        output wdata,
        input  rdata
    );

    modport csr (
        input  req,
        input  we,
        input  addr,
        input  op,
        input  wdata,
        output rdata
    );

endinterface

//--- logic/csr_counter.sv
`timescale 1ns/10ps

module csr_counter (
    input  logic                clk,
    input  logic                rst,
    input  logic                inc,
    input  logic                wr_lo,
    input  logic                wr_hi,
    input  csr_pkg::csr_word_t  wdata,
    output csr_pkg::counter_t   count
);
    import csr_pkg::*;

    // ----------------------------------------------------------------------
    // write of either word beats the increment
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (wr_lo) begin
            count[xlen-1:0] <= wdata;
        end else if (wr_hi) begin
            count[2*xlen-1:xlen] <= wdata;
        end else if (inc) begin
            count <= count + 64'd1;
        end
    end

    // decode gives one address per access
    a_one_word: assert property (
        @(posedge clk) disable iff (rst) !(wr_lo && wr_hi)
    );

endmodule

//--- logic/csr_file.sv
`timescale 1ns/10ps

module csr_file (
    input  logic                clk,
    input  logic                rst,
    csr_access_if.csr           acc,
    input  logic                tick,
    input  logic                retire,
    output csr_pkg::csr_word_t  tohost
);
    import csr_pkg::*;

    csr_word_t mscratch;
    counter_t  mcycle;
    counter_t  minstret;
    counter_t  mtime;
    csr_word_t wr_val;
    logic      wr_en;

    // ----------------------------------------------------------------------
    // read mux
    // ----------------------------------------------------------------------
    always_comb begin
        case (acc.addr)
            csr_tohost:    acc.rdata = tohost;
            csr_mscratch:  acc.rdata = mscratch;
            csr_mcycle:    acc.rdata = mcycle[xlen-1:0];
            csr_mcycleh:   acc.rdata = mcycle[2*xlen-1:xlen];
            csr_minstret:  acc.rdata = minstret[xlen-1:0];
            csr_minstreth: acc.rdata = minstret[2*xlen-1:xlen];
            csr_time:      acc.rdata = mtime[xlen-1:0];
            csr_timeh:     acc.rdata = mtime[2*xlen-1:xlen];
            // unmapped numbers read as zero
            default:       acc.rdata = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // new value against the current one
    // ----------------------------------------------------------------------
    always_comb begin
        case (acc.op)
            op_set:   wr_val = acc.rdata | acc.wdata;
            op_clear: wr_val = acc.rdata & ~acc.wdata;
            default:  wr_val = acc.wdata;
        endcase
    end

    assign wr_en = acc.req && acc.we;

    // plain registers
    always_ff @(posedge clk) begin
        if (rst) begin
            tohost   <= '0;
            mscratch <= '0;
        end else if (wr_en) begin
            case (acc.addr)
                csr_tohost:   tohost <= wr_val;
                csr_mscratch: mscratch <= wr_val;
                default: ;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // counters
    // ----------------------------------------------------------------------
    // cycle count, every clock
    csr_counter mcycle_cnt (
        .clk   (clk),
        .rst   (rst),
        .inc   (1'b1),
        .wr_lo (wr_en && (acc.addr == csr_mcycle)),
        .wr_hi (wr_en && (acc.addr == csr_mcycleh)),
        .wdata (wr_val),
        .count (mcycle)
    );

    // retired instructions
    csr_counter minstret_cnt (
        .clk   (clk),
        .rst   (rst),
        .inc   (retire),
        .wr_lo (wr_en && (acc.addr == csr_minstret)),
        .wr_hi (wr_en && (acc.addr == csr_minstreth)),
        .wdata (wr_val),
        .count (minstret)
    );

    // microseconds since reset
    csr_counter mtime_cnt (
        .clk   (clk),
        .rst   (rst),
        .inc   (tick),
        .wr_lo (wr_en && (acc.addr == csr_time)),
        .wr_hi (wr_en && (acc.addr == csr_timeh)),
        .wdata (wr_val),
        .count (mtime)
    );

endmodule

//--- logic/csr_pkg.sv
package csr_pkg;

    // ----------------------------------------------------------------------
    // widths
    // ----------------------------------------------------------------------
    localparam int xlen = 32;
    localparam int axi_addr_width = 16;

    // ----------------------------------------------------------------------
    // CSR numbers, standard machine-mode map plus tohost
    // ----------------------------------------------------------------------
    typedef enum logic [11:0] {
        csr_tohost    = 12'h51e,
        csr_mscratch  = 12'h340,
        csr_mcycle    = 12'hb00,
        csr_minstret  = 12'hb02,
        csr_mcycleh   = 12'hb80,
        csr_minstreth = 12'hb82,
        csr_time      = 12'hc01,
        csr_timeh     = 12'hc81
    } csr_addr_t;

    // write operation, carried in bus address bits 15:14
    typedef enum logic [1:0] {
        op_assign = 2'd0,
        op_set    = 2'd1,
        op_clear  = 2'd2
    } csr_op_t;

    // AXI response code
    typedef logic [1:0] axi_resp_t;
    localparam axi_resp_t resp_okay = 2'b00;

    // payloads
    typedef logic [xlen-1:0] csr_word_t;
    typedef logic [63:0] counter_t;

endpackage

//--- logic/csr_top.sv
`timescale 1ns/10ps

module csr_top #(
    parameter int unsigned CLOCK_FREQ = 100_000_000
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               awvalid,
    output logic                               awready,
    input  logic [csr_pkg::axi_addr_width-1:0] awaddr,
    input  logic                               wvalid,
    output logic                               wready,
    input  csr_pkg::csr_word_t                 wdata,
    output logic                               bvalid,
    input  logic                               bready,
    output csr_pkg::axi_resp_t                 bresp,
    input  logic                               arvalid,
    output logic                               arready,
    input  logic [csr_pkg::axi_addr_width-1:0] araddr,
    output logic                               rvalid,
    input  logic                               rready,
    output csr_pkg::csr_word_t                 rdata,
    output csr_pkg::axi_resp_t                 rresp,
    // one pulse per retired instruction
    input  logic                               retire,
    output csr_pkg::csr_word_t                 tohost
);

    logic tick;

    csr_access_if acc_if ();

    // ----------------------------------------------------------------------
    // bus side
    // ----------------------------------------------------------------------
    axil_csr_fsm fsm0 (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .acc     (acc_if.fsm)
    );

    // ----------------------------------------------------------------------
    // time base and registers
    // ----------------------------------------------------------------------
    us_timer #(
        .CLOCK_FREQ (CLOCK_FREQ)
    ) timer0 (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    csr_file csr0 (
        .clk    (clk),
        .rst    (rst),
        .acc    (acc_if.csr),
        .tick   (tick),
        .retire (retire),
        .tohost (tohost)
    );

endmodule

//--- logic/us_timer.sv
`timescale 1ns/10ps

module us_timer #(
    parameter int unsigned CLOCK_FREQ = 100_000_000
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);
    localparam int unsigned clocks_per_us = CLOCK_FREQ / 1_000_000;
    localparam int cnt_width = (clocks_per_us > 1) ? $clog2(clocks_per_us) : 1;

    logic [cnt_width-1:0] cnt;
    logic                 wrap;

    assign wrap = (cnt == cnt_width'(clocks_per_us - 1));

    // cycle count inside the current microsecond
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (wrap) begin
            cnt  <= '0;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

    a_cnt_range: assert property (
        @(posedge clk) disable iff (rst) 32'(cnt) < clocks_per_us
    );

endmodule

//--- run.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f tb.f --top-module tb_csr_top -o tb_csr_top &&
./obj_dir/tb_csr_top | tee /dev/stderr | grep "TESTS PASSED" > /dev/null &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- sim/csr_checker.sv
`timescale 1ns/10ps

module csr_checker (
    input logic        clk,
    input logic        rst,
    input logic        awvalid,
    input logic        awready,
    input logic        wvalid,
    input logic        wready,
    input logic        arvalid,
    input logic        arready,
    input logic        bvalid,
    input logic        bready,
    input logic [1:0]  bresp,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata,
    input logic [1:0]  rresp,
    input logic [31:0] tohost
);
    int          n_checks = 0;
    int          n_errors = 0;
    int          base_errors = 0;
    string       test_name = "reset";
    // expected read windows and tohost values in bus order
    logic [31:0] rd_lo_q[$];
    logic [31:0] rd_hi_q[$];
    logic [31:0] tohost_q[$];
    logic [31:0] tohost_exp;
    logic        wr_acc;
    int          wr_open = 0;
    int          rd_open = 0;
    logic        b_held = 1'b0;
    logic        r_held = 1'b0;
    logic [1:0]  bresp_held;
    logic [1:0]  rresp_held;
    logic [31:0] rdata_held;

    task automatic flag_error(input string what);
        n_errors++;
        $display("ERROR in %s: %s", test_name, what);
    endtask

    task automatic check_range(input string what, input logic [31:0] lo, input logic [31:0] hi,
                               input logic [31:0] act);
        n_checks++;
        if (act < lo || act > hi) begin
            n_errors++;
            if (lo == hi) begin
                $display("MISMATCH %s %s: expected %08h, actual %08h", test_name, what, lo, act);
            end else begin
                $display("MISMATCH %s %s: expected %08h..%08h, actual %08h",
                         test_name, what, lo, hi, act);
            end
        end
    endtask

    task automatic expect_read(input logic [31:0] lo, input logic [31:0] hi);
        rd_lo_q.push_back(lo);
        rd_hi_q.push_back(hi);
    endtask

    task automatic expect_tohost(input logic [31:0] value);
        tohost_q.push_back(value);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        base_errors = n_errors;
    endtask

    task automatic end_test();
        $display("test %s: %0d errors", test_name, n_errors - base_errors);
    endtask

    task automatic check_drained();
        if (wr_open != 0 || rd_open != 0) begin
            flag_error("a request was left without a response");
        end
        if (rd_lo_q.size() != 0 || tohost_q.size() != 0) begin
            flag_error("some expected responses never arrived");
        end
    endtask

    // ----------------------------------------------------------------------
    // bus monitor
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        if (rst) begin
            wr_open = 0;
            rd_open = 0;
            b_held = 1'b0;
            r_held = 1'b0;
        end else begin
            // a response waiting for ready must not move
            if (b_held && !bvalid) begin
                flag_error("bvalid dropped before bready");
            end else if (b_held) begin
                check_range("held bresp", {30'd0, bresp_held}, {30'd0, bresp_held},
                            {30'd0, bresp});
            end
            if (r_held && !rvalid) begin
                flag_error("rvalid dropped before rready");
            end else if (r_held) begin
                check_range("held rdata", rdata_held, rdata_held, rdata);
                check_range("held rresp", {30'd0, rresp_held}, {30'd0, rresp_held},
                            {30'd0, rresp});
            end
            // both write channels are taken in the same cycle
            if (awready != wready) begin
                flag_error("awready and wready were not raised together");
            end
            wr_acc = awvalid && awready && wvalid && wready;
            if (wr_acc || (arvalid && arready)) begin
                if (wr_open + rd_open != 0) begin
                    flag_error("address accepted while a response was pending");
                end
                if (wr_acc) wr_open++;
                else rd_open++;
            end
            if (bvalid && bready) begin
                if (wr_open == 0) flag_error("write response without a write request");
                else wr_open--;
                check_range("bresp", 32'd0, 32'd0, {30'd0, bresp});
                if (tohost_q.size() == 0) begin
                    flag_error("write response with no expected tohost");
                end else begin
                    tohost_exp = tohost_q.pop_front();
                    check_range("tohost port", tohost_exp, tohost_exp, tohost);
                end
            end
            if (rvalid && rready) begin
                if (rd_open == 0) flag_error("read data without a read request");
                else rd_open--;
                check_range("rresp", 32'd0, 32'd0, {30'd0, rresp});
                if (rd_lo_q.size() == 0) flag_error("read data with no expected value");
                else check_range("rdata", rd_lo_q.pop_front(), rd_hi_q.pop_front(), rdata);
            end
            b_held = bvalid && !bready;
            r_held = rvalid && !rready;
            bresp_held = bresp;
            rresp_held = rresp;
            rdata_held = rdata;
        end
    end

endmodule

//--- sim/tb_csr_top.sv
`timescale 1ns/10ps

module tb_csr_top;
    localparam int wait_limit = 64;
    localparam int cycle_bound = 4 * wait_limit;
    localparam logic [11:0] num_tohost = 12'h51e;
    localparam logic [11:0] num_mscratch = 12'h340;
    localparam logic [11:0] num_mcycle = 12'hb00;
    localparam logic [11:0] num_minstret = 12'hb02;
    localparam logic [11:0] num_minstreth = 12'hb82;
    localparam logic [11:0] num_time = 12'hc01;
    localparam logic [11:0] num_timeh = 12'hc81;

    logic        clk;
    logic        rst;
    logic        awvalid, wvalid, bready, arvalid, rready, retire;
    logic        awready, wready, bvalid, arready, rvalid;
    logic [15:0] awaddr, araddr;
    logic [31:0] wdata, rdata, tohost;
    logic [1:0]  bresp, rresp;
    // reference copies of the plain registers
    logic [31:0] model_tohost;
    logic [31:0] model_mscratch;

    csr_top #(.CLOCK_FREQ(125_000_000)) dut0 (.*);

    csr_checker chk0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // model and bus helpers
    // ----------------------------------------------------------------------
    function automatic logic [31:0] apply_op(input logic [1:0] op, input logic [31:0] cur,
                                             input logic [31:0] d);
        case (op)
            2'd1: return cur | d;
            2'd2: return cur & ~d;
            default: return d;
        endcase
    endfunction

    function automatic logic is_mapped(input logic [11:0] num);
        return num inside {num_tohost, num_mscratch, num_mcycle, 12'hb80,
                           num_minstret, num_minstreth, num_time, num_timeh};
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout: %s within %0d cycles", what, wait_limit);
        $display("TESTS FAILED");
        $finish;
    endtask

    // address handshake and then the response under random back-pressure
    task automatic wait_handshakes(input logic is_read);
        int   n;
        logic done;
        n = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            done = is_read ? arready : (awready && wready);
            n++;
            if (!done && n > wait_limit) report_timeout("address was not accepted");
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        arvalid <= 1'b0;
        bready  <= ($urandom % 4) != 0;
        rready  <= ($urandom % 4) != 0;
        n = 0;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            done = is_read ? (rvalid && rready) : (bvalid && bready);
            n++;
            if (!done) begin
                if (n > wait_limit) report_timeout("no response arrived");
                bready <= ($urandom % 4) != 0;
                rready <= ($urandom % 4) != 0;
            end
        end
        bready <= 1'b0;
        rready <= 1'b0;
    endtask

    task automatic bus_write(input logic [11:0] num, input logic [1:0] op,
                             input logic [31:0] data);
        chk0.expect_tohost(model_tohost);
        awaddr  <= {op, num, 2'b00};
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        wait_handshakes(1'b0);
    endtask

    // random op bits on reads
    task automatic bus_read(input logic [11:0] num, input logic [31:0] lo, input logic [31:0] hi,
                            output logic [31:0] data);
        chk0.expect_read(lo, hi);
        araddr  <= {2'($urandom % 4), num, 2'b00};
        arvalid <= 1'b1;
        wait_handshakes(1'b1);
        data = rdata;
    endtask

    task automatic pulse_retire();
        repeat (1 + $urandom % 3) @(posedge clk);
        retire <= 1'b1;
        @(posedge clk);
        retire <= 1'b0;
    endtask

    task automatic finish_test();
        repeat (2) @(posedge clk);
        chk0.end_test();
    endtask

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin
        logic [11:0] num;
        logic [1:0]  op;
        logic [31:0] data, first, second, n_ret;
        void'($urandom(54));
        rst = 1'b1;
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b0;
        arvalid = 1'b0;
        rready = 1'b0;
        retire = 1'b0;
        awaddr = '0;
        araddr = '0;
        wdata = '0;
        model_tohost = '0;
        model_mscratch = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        chk0.start_test("reg_ops");
        for (int i = 0; i < 200; i++) begin
            num = (($urandom % 2) == 0) ? num_tohost : num_mscratch;
            op = 2'($urandom % 3);
            data = $urandom;
            if (num == num_tohost) model_tohost = apply_op(op, model_tohost, data);
            else model_mscratch = apply_op(op, model_mscratch, data);
            bus_write(num, op, data);
            data = (num == num_tohost) ? model_tohost : model_mscratch;
            bus_read(num, data, data, first);
        end
        finish_test();

        chk0.start_test("retire");
        bus_write(num_minstret, 2'd0, 32'd0);
        n_ret = 1 + $urandom % 40;
        for (int i = 0; i < n_ret; i++) pulse_retire();
        bus_read(num_minstret, n_ret, n_ret, first);
        bus_read(num_minstreth, 32'd0, 32'd0, first);
        finish_test();

        chk0.start_test("mcycle");
        data = $urandom & 32'h0fff_ffff;
        bus_write(num_mcycle, 2'd0, data);
        bus_read(num_mcycle, data, data + cycle_bound, first);
        bus_read(num_mcycle, first + 1, first + cycle_bound, second);
        finish_test();

        // 125 cycles per tick
        chk0.start_test("time");
        bus_write(num_time, 2'd0, 32'd0);
        bus_write(num_timeh, 2'd0, 32'd0);
        repeat (1000) @(posedge clk);
        bus_read(num_time, 32'd7, 32'd9, first);
        bus_read(num_timeh, 32'd0, 32'd0, first);
        finish_test();

        chk0.start_test("unmapped");
        for (int i = 0; i < 20; i++) begin
            num = 12'($urandom);
            if (is_mapped(num)) num = num ^ 12'h001;
            bus_read(num, 32'd0, 32'd0, first);
            bus_write(num, 2'($urandom % 3), $urandom);
            bus_read(num_tohost, model_tohost, model_tohost, first);
            bus_read(num_mscratch, model_mscratch, model_mscratch, first);
        end
        finish_test();

        chk0.check_drained();
        $display("%0d checks, %0d errors", chk0.n_checks, chk0.n_errors);
        if (chk0.n_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
logic/csr_pkg.sv
logic/csr_access_if.sv
logic/axil_csr_fsm.sv
logic/us_timer.sv
logic/csr_counter.sv
logic/csr_file.sv
logic/csr_top.sv
sim/csr_checker.sv
sim/tb_csr_top.sv
